/* hdl/reorder_macros.svh */
`ifndef REORDER_MACROS_SVH
`define REORDER_MACROS_SVH

// physical and logical lanes of the receive path
`define REORDER_N_LANES 20

// one 64b/66b block, sync header included
`define REORDER_NB_BLOCK 66

// wide enough for any lane number, ceil(log2(lanes))
`define REORDER_NB_ID 5

`endif

/* hdl/reorder_pkg.sv */
`include "reorder_macros.svh"

package reorder_pkg;

    // one pcs block
    typedef logic [`REORDER_NB_BLOCK-1:0] block_t;

    // logical lane number or physical lane index
    typedef logic [`REORDER_NB_ID-1:0] lane_id_t;

    // tag sits above the block, as delivered by each lane
    typedef struct packed {
        logic   tag;
        block_t block;
    } lane_word_t;

    // indexed by physical lane
    typedef lane_word_t [`REORDER_N_LANES-1:0] lane_bundle_t;

    // received ids by physical lane, or selectors by logical lane
    typedef lane_id_t [`REORDER_N_LANES-1:0] id_table_t;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_CHECK,
        SCAN_LOCKED,
        SCAN_ERROR
    } scan_state_t;

endpackage

/* hdl/lane_reorder.sv */
`timescale 1ns/1ps
`include "reorder_macros.svh"

module lane_reorder
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_enable,
    input  logic                   i_reset_order,
    input  logic                   i_deskew_done,
    input  reorder_pkg::id_table_t i_logical_rx_ID,
    output reorder_pkg::id_table_t o_reorder_mux_selector,
    output logic                   o_update_selectors,
    output logic                   o_order_error
);

    localparam reorder_pkg::lane_id_t LAST_INDEX =
        reorder_pkg::lane_id_t'(`REORDER_N_LANES - 1);

    reorder_pkg::scan_state_t state;
    reorder_pkg::lane_id_t    scan_index;
    reorder_pkg::id_table_t   scan_table;
    logic                     all_unique;
    logic [`REORDER_NB_ID:0]  match_count;
    reorder_pkg::lane_id_t    match_lane;

    // which physical lanes report the logical index under scan
    always_comb
    begin
        match_count = '0;
        match_lane  = '0;
        for (int p = 0; p < `REORDER_N_LANES; p++)
        begin
            if (i_logical_rx_ID[p] == scan_index)
            begin
                match_count = match_count + 1'b1;
                match_lane  = reorder_pkg::lane_id_t'(p);
            end
        end
    end

    // scan fsm, a restart request wins over any state
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state              <= reorder_pkg::SCAN_IDLE;
            scan_index         <= '0;
            all_unique         <= 1'b0;
            o_update_selectors <= 1'b0;
            o_order_error      <= 1'b0;
            for (int i = 0; i < `REORDER_N_LANES; i++)
            begin
                o_reorder_mux_selector[i] <= reorder_pkg::lane_id_t'(i);
            end
        end
        else if (i_enable)
        begin
            if (i_reset_order)
            begin
                state              <= reorder_pkg::SCAN_RUN;
                scan_index         <= '0;
                all_unique         <= 1'b1;
                o_update_selectors <= 1'b0;
                o_order_error      <= 1'b0;
            end
            else
            begin
                case (state)
                    reorder_pkg::SCAN_RUN:
                    begin
                        // lanes no longer aligned, so the ids mean nothing
                        if (!i_deskew_done)
                        begin
                            state <= reorder_pkg::SCAN_IDLE;
                        end
                        else
                        begin
                            all_unique <= all_unique && (match_count == 1);
                            if (scan_index == LAST_INDEX)
                            begin
                                state <= reorder_pkg::SCAN_CHECK;
                            end
                            else
                            begin
                                scan_index <= scan_index + 1'b1;
                            end
                        end
                    end
                    reorder_pkg::SCAN_CHECK:
                    begin
                        if (all_unique)
                        begin
                            o_reorder_mux_selector <= scan_table;
                            o_update_selectors     <= 1'b1;
                            state                  <= reorder_pkg::SCAN_LOCKED;
                        end
                        else
                        begin
                            // old selectors stay in place
                            o_order_error <= 1'b1;
                            state         <= reorder_pkg::SCAN_ERROR;
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // candidate table, filled one logical lane per cycle
    always_ff @(posedge i_clock)
    begin
        if (i_enable && (state == reorder_pkg::SCAN_RUN))
        begin
            scan_table[scan_index] <= match_lane;
        end
    end

endmodule

/* hdl/lane_swap.sv */
`timescale 1ns/1ps
`include "reorder_macros.svh"

module lane_swap
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_valid,
    input  logic                      i_reorder_done,
    input  reorder_pkg::lane_bundle_t i_data,
    input  reorder_pkg::id_table_t    i_lane_ids,
    output reorder_pkg::lane_word_t   o_data,
    output logic                      o_valid
);

    localparam reorder_pkg::lane_id_t LAST_LANE =
        reorder_pkg::lane_id_t'(`REORDER_N_LANES - 1);

    reorder_pkg::id_table_t active_table;
    reorder_pkg::lane_id_t  lane_count;
    logic                   streaming;

    // identity until the first validated mapping arrives
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < `REORDER_N_LANES; i++)
            begin
                active_table[i] <= reorder_pkg::lane_id_t'(i);
            end
        end
        else if (i_enable && i_reorder_done)
        begin
            active_table <= i_lane_ids;
        end
    end

    // logical lane counter, a new strobe restarts at lane 0
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            streaming  <= 1'b0;
            lane_count <= '0;
            o_valid    <= 1'b0;
        end
        else if (i_enable)
        begin
            o_valid <= streaming;
            if (i_valid)
            begin
                streaming  <= 1'b1;
                lane_count <= '0;
            end
            else if (streaming)
            begin
                if (lane_count == LAST_LANE)
                begin
                    streaming  <= 1'b0;
                    lane_count <= '0;
                end
                else
                begin
                    lane_count <= lane_count + 1'b1;
                end
            end
        end
    end

    // word of the physical lane that carries the current logical lane
    always_ff @(posedge i_clock)
    begin
        if (i_enable && streaming)
        begin
            o_data <= i_data[active_table[lane_count]];
        end
    end

endmodule

/* hdl/reorder_toplevel.sv */
`timescale 1ns/1ps

module reorder_toplevel
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_valid,
    input  logic                      i_deskew_done,
    input  logic                      i_rf_reset_order,
    input  reorder_pkg::id_table_t    i_logical_rx_ID,
    input  reorder_pkg::lane_bundle_t i_data,
    output reorder_pkg::block_t       o_data,
    output logic                      o_tag,
    output logic                      o_valid,
    output logic                      o_order_locked,
    output logic                      o_order_error
);

    reorder_pkg::lane_bundle_t data_d;
    reorder_pkg::id_table_t    ordered_ids;
    reorder_pkg::lane_word_t   swapped_word;
    logic                      deskew_done_prev;
    logic                      table_ready;
    logic                      table_ready_prev;
    logic                      restart_order;
    logic                      load_table;

    // bundle held for the whole streaming window
    always_ff @(posedge i_clock)
    begin
        if (i_enable && i_valid)
        begin
            data_d <= i_data;
        end
    end

    // delayed levels for edge detection
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            deskew_done_prev <= 1'b0;
            table_ready_prev <= 1'b0;
        end
        else if (i_enable)
        begin
            deskew_done_prev <= i_deskew_done;
            table_ready_prev <= table_ready;
        end
    end

    // rescan on fresh alignment or on register request
    assign restart_order = (i_deskew_done && !deskew_done_prev) || i_rf_reset_order;
    assign load_table    = table_ready && !table_ready_prev;

    lane_reorder u_lane_reorder
    (
        .i_clock                (i_clock),
        .i_reset                (i_reset),
        .i_enable               (i_enable),
        .i_reset_order          (restart_order),
        .i_deskew_done          (i_deskew_done),
        .i_logical_rx_ID        (i_logical_rx_ID),
        .o_reorder_mux_selector (ordered_ids),
        .o_update_selectors     (table_ready),
        .o_order_error          (o_order_error)
    );

    lane_swap u_lane_swap
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (i_enable),
        .i_valid        (i_valid),
        .i_reorder_done (load_table),
        .i_data         (data_d),
        .i_lane_ids     (ordered_ids),
        .o_data         (swapped_word),
        .o_valid        (o_valid)
    );

    assign o_tag          = swapped_word.tag;
    assign o_data         = swapped_word.block;
    assign o_order_locked = table_ready;

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial
    begin
        o_clock = 1'b0;
        forever #HALF_PERIOD o_clock = ~o_clock;
    end

    // released on a clock edge, the design reset is synchronous
    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

/* sim/reorder_chk.sv */
`timescale 1ns/1ps

module reorder_chk
(
    input logic i_clock,
    input logic i_reset,
    input logic i_enable,
    input logic i_valid,
    input logic i_restart,
    input logic i_out_valid,
    input logic i_locked,
    input logic i_error
);

    int unsigned fail_count = 0;
    logic [5:0]  valid_run;
    logic [5:0]  since_restart;

    // both counters advance on enabled cycles only and saturate
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_run     <= '0;
            since_restart <= '0;
        end
        else if (i_enable)
        begin
            if (i_valid)
                valid_run <= '0;
            else if (i_out_valid && valid_run != '1)
                valid_run <= valid_run + 1'b1;
            if (i_restart)
                since_restart <= '0;
            else if (since_restart != '1)
                since_restart <= since_restart + 1'b1;
        end
    end

    valid_window: assert property (@(posedge i_clock) disable iff (i_reset)
        valid_run <= 6'd20)
    else
    begin
        $error("o_valid stayed high for more than 20 cycles after a strobe");
        fail_count++;
    end

    levels_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_locked && i_error))
    else
    begin
        $error("lock and error levels are high together");
        fail_count++;
    end

    // scan of 20 lanes plus the check cycle
    level_latency: assert property (@(posedge i_clock) disable iff (i_reset)
        ($rose(i_locked) || $rose(i_error)) |-> since_restart >= 6'd21)
    else
    begin
        $error("lock or error level rose too soon after a restart");
        fail_count++;
    end

endmodule

/* sim/reorder_tb.sv */
`timescale 1ns/1ps
`include "reorder_macros.svh"

module reorder_tb;

    localparam int N_ROWS       = 7;
    localparam int N_LANES      = `REORDER_N_LANES;
    localparam int CLOCK_PERIOD = 20;

    typedef enum logic [1:0] {EV_NONE, EV_DESKEW, EV_RF} event_t;
    typedef enum logic [1:0] {EXP_IDLE, EXP_LOCK, EXP_ERROR} result_t;

    // hold_len of 0 keeps enable high for the whole row
    typedef struct packed {
        event_t                event_kind;
        reorder_pkg::lane_id_t rotation;
        logic                  duplicate;
        result_t               result;
        reorder_pkg::lane_id_t hold_at;
        logic [2:0]            hold_len;
    } row_t;

    row_t scenarios [N_ROWS] = '{
        '{EV_NONE,   5'd0,  1'b0, EXP_IDLE,  5'd0,  3'd0},
        '{EV_DESKEW, 5'd3,  1'b0, EXP_LOCK,  5'd0,  3'd0},
        '{EV_RF,     5'd3,  1'b1, EXP_ERROR, 5'd0,  3'd0},
        '{EV_RF,     5'd7,  1'b0, EXP_LOCK,  5'd0,  3'd0},
        '{EV_NONE,   5'd11, 1'b0, EXP_LOCK,  5'd0,  3'd0},
        '{EV_DESKEW, 5'd13, 1'b0, EXP_LOCK,  5'd6,  3'd4},
        '{EV_NONE,   5'd13, 1'b0, EXP_LOCK,  5'd15, 3'd3}
    };

    logic                      i_clock;
    logic                      i_reset;
    logic                      i_enable;
    logic                      i_valid;
    logic                      i_deskew_done;
    logic                      i_rf_reset_order;
    reorder_pkg::id_table_t    i_logical_rx_ID;
    reorder_pkg::lane_bundle_t i_data;
    reorder_pkg::block_t       o_data;
    logic                      o_tag;
    logic                      o_valid;
    logic                      o_order_locked;
    logic                      o_order_error;

    logic [31:0]               lfsr_state = 32'd92953;
    reorder_pkg::id_table_t    expected_sel;
    reorder_pkg::lane_word_t   got_words [N_LANES];

    tb_clock_gen clock_gen_inst (.o_clock(i_clock), .o_reset(i_reset));

    reorder_toplevel reorder_toplevel_inst (.*);

    bind reorder_toplevel reorder_chk chk_inst
    (
        .i_clock(i_clock), .i_reset(i_reset), .i_enable(i_enable), .i_valid(i_valid),
        .i_restart(restart_order), .i_out_valid(o_valid),
        .i_locked(o_order_locked), .i_error(o_order_error)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // physical lane p reports logical id (p + r) mod 20
    function automatic reorder_pkg::id_table_t lane_ids(input int r, input logic duplicate);
        reorder_pkg::id_table_t ids;
        for (int p = 0; p < N_LANES; p++)
            ids[p] = reorder_pkg::lane_id_t'((p + r) % N_LANES);
        if (duplicate)
            ids[1] = ids[0];
        return ids;
    endfunction

    // logical lane k then comes from physical lane (k - r) mod 20
    function automatic reorder_pkg::id_table_t selector_for(input int r);
        reorder_pkg::id_table_t sel;
        for (int k = 0; k < N_LANES; k++)
            sel[k] = reorder_pkg::lane_id_t'((k + N_LANES - r) % N_LANES);
        return sel;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_block(input string name, input reorder_pkg::block_t actual,
                                 input reorder_pkg::block_t expected);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s: actual 0x%h, expected 0x%h",
                                     name, actual, expected));
    endtask

    task automatic compare_tag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s: actual 0x%h, expected 0x%h",
                                     name, actual, expected));
    endtask

    task automatic compare_level(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s: actual 0x%h, expected 0x%h",
                                     name, actual, expected));
    endtask

    // one lfsr step per bit, tag bit included
    task automatic random_bundle(output reorder_pkg::lane_bundle_t bundle);
        logic [`REORDER_NB_BLOCK:0] bits;
        for (int p = 0; p < N_LANES; p++)
        begin
            for (int b = 0; b <= `REORDER_NB_BLOCK; b++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                bits[b] = lfsr_state[0];
            end
            bundle[p] = bits;
        end
    endtask

    // returns just after the edge that samples the restart
    task automatic apply_event(input event_t kind, input reorder_pkg::id_table_t ids);
        @(posedge i_clock);
        i_logical_rx_ID <= ids;
        if (kind == EV_DESKEW)
        begin
            i_deskew_done <= 1'b0;
            @(posedge i_clock);
            i_deskew_done <= 1'b1;
        end
        else if (kind == EV_RF)
            i_rf_reset_order <= 1'b1;
        @(posedge i_clock);
        i_rf_reset_order <= 1'b0;
    endtask

    task automatic wait_for_result();
        int cycles;
        cycles = 0;
        @(negedge i_clock);
        compare_level("o_order_locked after restart", o_order_locked, 1'b0);
        compare_level("o_order_error after restart", o_order_error, 1'b0);
        while (!(o_order_locked || o_order_error))
        begin
            if (cycles == 40)
                report_failure("No lock or error level within 40 cycles of the restart");
            @(negedge i_clock);
            cycles++;
        end
    endtask

    task automatic send_bundle(input reorder_pkg::lane_bundle_t bundle);
        @(posedge i_clock);
        i_data  <= bundle;
        i_valid <= 1'b1;
        @(posedge i_clock);
        i_valid <= 1'b0;
    endtask

    // one valid word per enabled edge, enable drops once hold_at words are in
    task automatic collect_words(input int hold_at, input int hold_len);
        int   count;
        int   hold_left;
        logic hold_started;
        logic edge_enabled;
        count        = 0;
        hold_left    = 0;
        hold_started = 1'b0;
        edge_enabled = i_enable;
        while (count < N_LANES)
        begin
            @(posedge i_clock);
            if (hold_len > 0 && count == hold_at && !hold_started)
            begin
                i_enable     <= 1'b0;
                hold_started = 1'b1;
                hold_left    = hold_len;
            end
            else if (hold_left > 0)
            begin
                hold_left--;
                if (hold_left == 0)
                    i_enable <= 1'b1;
            end
            @(negedge i_clock);
            if (edge_enabled)
            begin
                compare_level($sformatf("o_valid lane %0d", count), o_valid, 1'b1);
                got_words[count] = {o_tag, o_data};
                count++;
            end
            else
            begin
                compare_block("o_data while disabled", o_data, got_words[count-1].block);
                compare_tag("o_tag while disabled", o_tag, got_words[count-1].tag);
            end
            edge_enabled = i_enable;
        end
    endtask

    task automatic check_bundle(input reorder_pkg::lane_bundle_t bundle);
        reorder_pkg::lane_word_t want;
        for (int k = 0; k < N_LANES; k++)
        begin
            want = bundle[expected_sel[k]];
            compare_block($sformatf("o_data lane %0d", k), got_words[k].block, want.block);
            compare_tag($sformatf("o_tag lane %0d", k), got_words[k].tag, want.tag);
        end
    endtask

    // a row takes well under 100 cycles
    initial
    begin
        #(N_ROWS * 100 * CLOCK_PERIOD + 8 * CLOCK_PERIOD);
        report_failure("Timeout, the scenario table did not finish in time");
    end

    initial
    begin
        reorder_pkg::lane_bundle_t bundle;
        row_t                      row;
        i_enable         <= 1'b1;
        i_valid          <= 1'b0;
        i_deskew_done    <= 1'b0;
        i_rf_reset_order <= 1'b0;
        i_logical_rx_ID  <= lane_ids(0, 1'b0);
        i_data           <= '0;
        expected_sel = selector_for(0);
        wait (!i_reset);
        for (int r = 0; r < N_ROWS; r++)
        begin
            row = scenarios[r];
            apply_event(row.event_kind, lane_ids(row.rotation, row.duplicate));
            if (row.event_kind == EV_NONE)
                repeat (25) @(negedge i_clock);
            else
                wait_for_result();
            compare_level("o_order_locked", o_order_locked, row.result == EXP_LOCK);
            compare_level("o_order_error", o_order_error, row.result == EXP_ERROR);
            // an error or a missing restart leaves the old table in place
            if (row.event_kind != EV_NONE && row.result == EXP_LOCK)
                expected_sel = selector_for(row.rotation);
            repeat (2) @(posedge i_clock);
            for (int b = 0; b < 2; b++)
            begin
                random_bundle(bundle);
                send_bundle(bundle);
                collect_words(b == 0 ? row.hold_at : 0, b == 0 ? row.hold_len : 0);
                check_bundle(bundle);
            end
        end
        if (reorder_toplevel_inst.chk_inst.fail_count == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            $display("Simulation failed");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

/* files.f */
+incdir+hdl
hdl/reorder_pkg.sv
hdl/lane_reorder.sv
hdl/lane_swap.sv
hdl/reorder_toplevel.sv
sim/tb_clock_gen.sv
sim/reorder_chk.sv
sim/reorder_tb.sv
